/* Bender.yml */
package:
  name: gba_loader

sources:
  - ioctl_pkg.sv
  - gba_load_pkg.sv
  - download_decoder.sv
  - cart_scanner.sv
  - cart_quirks.sv
  - bios_loader.sv
  - cheat_loader.sv
  - rom_writer.sv
  - gba_loader_top.sv
  - target: simulation
    files:
      - tb_gba_loader.sv

/* bios_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module bios_loader import ioctl_pkg::*, gba_load_pkg::*; (
	input  wire             clk_sys,
	input  wire             reset,
	input  wire ioctl_bus_t host,
	input  wire             bios_active,
	input  wire             homebrew_bios,  // Keep the built-in replacement
	output logic            bios_wr,
	output bios_addr_t      bios_addr,
	output bios_word_t      bios_data
);

	logic take;  // BIOS halfword accepted this cycle

	assign take = bios_active & host.wr & ~homebrew_bios;

	// Strobe goes out with the upper half
	always_ff @(posedge clk_sys) begin
		if (reset)
			bios_wr <= 1'b0;
		else
			bios_wr <= take & host.addr[1];
	end

	// Word assembly, low half first
	always_ff @(posedge clk_sys) begin
		if (take) begin
			if (!host.addr[1]) begin
				bios_data[15:0] <= host.dout;
			end else begin
				bios_data[31:16] <= host.dout;
				bios_addr        <= host.addr[13:2];  // Byte to word address
			end
		end
	end

endmodule

`default_nettype wire

/* cart_quirks.sv */
`timescale 1ns/1ps
`default_nettype none

module cart_quirks import ioctl_pkg::*, gba_load_pkg::*; (
	input  wire             clk_sys,
	input  wire             reset,
	input  wire ioctl_bus_t host,
	input  wire             cart_active,
	input  wire             cart_start,
	output logic            sram_quirk,
	output logic            remap_quirk
);

	cart_title_t            title;      // Header title, first byte on top
	ioctl_addr_t            title_off;  // Byte offset into the title field
	logic [3:0]             title_pos;  // Halfword slot counted in bytes from the bottom
	logic                   cart_wr;
	logic                   in_title;   // Write lands inside bytes 160..171
	logic                   at_check;   // Write at byte 172, title complete
	logic [QUIRK_COUNT-1:0] match;      // One bit per table entry

	assign cart_wr   = cart_active & host.wr;
	assign title_off = host.addr - HEADER_TITLE_BASE;
	assign title_pos = 4'(HEADER_TITLE_LEN - 2) - title_off[3:0];
	assign in_title  = (host.addr >= HEADER_TITLE_BASE) &&
		(title_off < ioctl_addr_t'(HEADER_TITLE_LEN));
	assign at_check  = (title_off == ioctl_addr_t'(HEADER_TITLE_LEN));

	// Compare against every entry in parallel
	always_comb begin
		for (int i = 0; i < QUIRK_COUNT; i++) begin
			match[i] = (title == QUIRK_TITLES[i]);
		end
	end

	// ======================================
	// Title capture
	// ======================================

	always_ff @(posedge clk_sys) begin
		if (cart_wr && in_title)
			title[{title_pos, 3'b000} +: 16] <= {host.dout[7:0], host.dout[15:8]};
	end

	// Quirk flags
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sram_quirk  <= 1'b0;
			remap_quirk <= 1'b0;
		end else if (cart_start) begin
			sram_quirk  <= 1'b0;  // New game, forget the last one
			remap_quirk <= 1'b0;
		end else if (cart_wr && at_check) begin
			sram_quirk  <= |match;                // Every entry needs SRAM
			remap_quirk <= |(match & QUIRK_REMAP);
		end
	end

endmodule

`default_nettype wire

/* cart_scanner.sv */
`timescale 1ns/1ps
`default_nettype none

module cart_scanner import ioctl_pkg::*, gba_load_pkg::*; (
	input  wire             clk_sys,
	input  wire             reset,
	input  wire ioctl_bus_t host,
	input  wire             cart_active,
	input  wire             cart_start,
	input  wire             cart_end,
	output logic            cart_loaded,
	output cart_type_t      cart_type,
	output logic            flash_1m,
	output ioctl_addr_t     last_addr
);

	logic [63:0] history;   // Last eight bytes, newest in the low byte
	logic        cart_wr;   // Cartridge halfword on the bus
	logic        hit_low;   // Marker ends on the low byte of this write
	logic        hit_high;  // Marker ends on the high byte

	assign cart_wr  = cart_active & host.wr;
	assign hit_low  = ({history, host.dout[7:0]} == FLASH_MARKER);
	assign hit_high = ({history[55:0], host.dout[7:0], host.dout[15:8]} == FLASH_MARKER);

	// ======================================
	// Cartridge status
	// ======================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_loaded <= 1'b0;
			cart_type   <= '0;
			flash_1m    <= 1'b0;
		end else begin
			if (cart_start) begin
				cart_type   <= host.index[7:6];  // Index is still stable here
				cart_loaded <= 1'b1;             // Stays set until reset
				flash_1m    <= 1'b0;
			end
			if (cart_wr && (hit_low || hit_high))
				flash_1m <= 1'b1;  // Wins over the clear above
		end
	end

	// Byte history and end address
	always_ff @(posedge clk_sys) begin
		if (cart_wr)
			history <= {history[47:0], host.dout[7:0], host.dout[15:8]};  // Low byte first
		if (cart_end)
			last_addr <= host.addr;  // Host leaves the address of its last write
	end

endmodule

`default_nettype wire

/* cheat_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module cheat_loader import ioctl_pkg::*, gba_load_pkg::*; (
	input  wire             clk_sys,
	input  wire             reset,
	input  wire ioctl_bus_t host,
	input  wire             code_active,
	output cheat_code_t     cheat_code,
	output logic            cheat_valid
);

	logic       code_wr;  // Code halfword on the bus
	logic [3:0] offset;   // Halfword place inside the 16-byte code

	assign code_wr = code_active & host.wr;
	assign offset  = host.addr[3:0];

	// Last halfword completes the code
	always_ff @(posedge clk_sys) begin
		if (reset)
			cheat_valid <= 1'b0;
		else
			cheat_valid <= code_wr && (offset == 4'd14);
	end

	// ======================================
	// Field assembly
	// ======================================

	// Values arrive big endian, the loader already swapped them
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (offset)
				4'd0:  cheat_code.flags[15:0]    <= host.dout;
				4'd2:  cheat_code.flags[31:16]   <= host.dout;
				4'd4:  cheat_code.addr[15:0]     <= host.dout;  // Target address
				4'd6:  cheat_code.addr[31:16]    <= host.dout;
				4'd8:  cheat_code.compare[15:0]  <= host.dout;  // Old value
				4'd10: cheat_code.compare[31:16] <= host.dout;
				4'd12: cheat_code.replace[15:0]  <= host.dout;  // New value
				4'd14: cheat_code.replace[31:16] <= host.dout;
				default: ;                                      // Odd offsets never come
			endcase
		end
	end

endmodule

`default_nettype wire

/* download_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module download_decoder import ioctl_pkg::*; (
	input  wire             clk_sys,
	input  wire             reset,
	input  wire ioctl_bus_t host,
	output dl_flags_t       flags,
	output logic            cart_start,
	output logic            cart_end,
	output logic            cheat_clear
);

	logic is_bios;      // Index decode
	logic is_code;
	logic cart_d1;      // Cart flag one cycle back
	logic download_d1;  // Raw download level one cycle back

	assign is_bios = (host.index == INDEX_BIOS);
	assign is_code = (host.index == INDEX_CODE);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			flags       <= '0;
			cart_d1     <= 1'b0;
			download_d1 <= 1'b0;
			cart_start  <= 1'b0;
			cart_end    <= 1'b0;
			cheat_clear <= 1'b0;
		end else begin
			// Kind of the running download
			flags.bios <= host.download & is_bios;
			flags.code <= host.download & is_code;
			flags.cart <= host.download & ~is_bios & ~is_code;  // Anything else

			cart_d1     <= flags.cart;
			download_d1 <= host.download;

			cart_start  <= flags.cart & ~cart_d1;  // Rising edge of the cart flag
			cart_end    <= ~flags.cart & cart_d1;  // Falling edge
			// Wipe the old code list when a new one starts
			cheat_clear <= host.download & ~download_d1 & is_code;
		end
	end

endmodule

`default_nettype wire

/* gba_load_pkg.sv */
`default_nettype none

package gba_load_pkg;

	import ioctl_pkg::*;

	// ======================================
	// BIOS and cheat codes
	// ======================================

	typedef logic [11:0] bios_addr_t;  // Word address inside the 16 KB BIOS
	typedef logic [31:0] bios_word_t;

	// One code as the core takes it, flags on top
	typedef struct packed {
		logic [31:0] flags;    // 127:96
		logic [31:0] addr;     // 95:64
		logic [31:0] compare;  // 63:32
		logic [31:0] replace;  // 31:0
	} cheat_code_t;

	// ======================================
	// Cartridge and ROM channel
	// ======================================

	typedef logic [1:0]  cart_type_t;   // Taken from index bits 7:6
	typedef logic [95:0] cart_title_t;  // 12 header bytes, first byte on top
	typedef logic [25:0] rom_addr_t;    // Halfword address into memory

	// Write request towards the memory channel, 43 bits
	typedef struct packed {
		logic        req;   // Single-cycle request
		rom_addr_t   addr;
		ioctl_data_t data;
	} rom_req_t;

	localparam ioctl_addr_t ROM_START         = 27'd786432;  // Byte offset of the game pak
	localparam ioctl_addr_t HEADER_TITLE_BASE = 27'd160;     // 0xA0 in the pak header
	localparam int          HEADER_TITLE_LEN  = 12;

	localparam logic [71:0] FLASH_MARKER = "FLASH1M_V";  // Save type tag in the ROM text

	// Quirk table, titles padded with zero bytes
	localparam int QUIRK_COUNT = 8;

	localparam cart_title_t QUIRK_TITLES [QUIRK_COUNT] = '{
		"ROCKY BOXING",               // SRAM only
		"DBZ LGCYGOKU",
		"DBZ TAIKETSU",
		{"IRIDIONII", 24'h000000},
		{"BOMBER MAN", 16'h0000},     // Remapped NES ports from here on
		{"CASTLEVANIA", 8'h00},
		{"SUPER MARIO", 8'h00},
		{"MAPPY", 56'h00000000000000}
	};

	localparam logic [QUIRK_COUNT-1:0] QUIRK_REMAP = 8'b1111_0000;  // Bit i for entry i

endpackage

`default_nettype wire

/* gba_loader_top.sv */
`timescale 1ns/1ps
`default_nettype none

module gba_loader_top import ioctl_pkg::*, gba_load_pkg::*; (
	input  wire             clk_sys,
	input  wire             reset,
	input  wire ioctl_bus_t host,
	input  wire             homebrew_bios,
	input  wire             mem_ack,
	output logic            ioctl_wait,
	output rom_req_t        rom,
	output logic            bios_wr,
	output bios_addr_t      bios_addr,
	output bios_word_t      bios_data,
	output cheat_code_t     cheat_code,
	output logic            cheat_valid,
	output logic            cheat_clear,
	output logic            cart_loaded,
	output cart_type_t      cart_type,
	output logic            flash_1m,
	output ioctl_addr_t     last_addr,
	output logic            sram_quirk,
	output logic            remap_quirk
);

	dl_flags_t flags;       // Kind of the running download
	logic      cart_start;  // Cartridge download edges
	logic      cart_end;

	// ======================================
	// Download sorting
	// ======================================

	download_decoder download_decoder_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.host        (host),
		.flags       (flags),
		.cart_start  (cart_start),
		.cart_end    (cart_end),
		.cheat_clear (cheat_clear)
	);

	// Cartridge side
	cart_scanner cart_scanner_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.host        (host),
		.cart_active (flags.cart),
		.cart_start  (cart_start),
		.cart_end    (cart_end),
		.cart_loaded (cart_loaded),
		.cart_type   (cart_type),
		.flash_1m    (flash_1m),
		.last_addr   (last_addr)
	);

	cart_quirks cart_quirks_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.host        (host),
		.cart_active (flags.cart),
		.cart_start  (cart_start),
		.sram_quirk  (sram_quirk),
		.remap_quirk (remap_quirk)
	);

	rom_writer rom_writer_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.host        (host),
		.cart_active (flags.cart),
		.mem_ack     (mem_ack),
		.rom         (rom),
		.ioctl_wait  (ioctl_wait)
	);

	// BIOS and cheat codes
	bios_loader bios_loader_i (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.host          (host),
		.bios_active   (flags.bios),
		.homebrew_bios (homebrew_bios),
		.bios_wr       (bios_wr),
		.bios_addr     (bios_addr),
		.bios_data     (bios_data)
	);

	cheat_loader cheat_loader_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.host        (host),
		.code_active (flags.code),
		.cheat_code  (cheat_code),
		.cheat_valid (cheat_valid)
	);

endmodule

`default_nettype wire

/* ioctl_pkg.sv */
`default_nettype none

package ioctl_pkg;

	// ======================================
	// Host download bus
	// ======================================

	typedef logic [26:0] ioctl_addr_t;   // Byte address from the host
	typedef logic [15:0] ioctl_data_t;   // One halfword per strobe
	typedef logic [7:0]  ioctl_index_t;  // Picks what is being loaded

	// Whole bus as seen by the loader, 53 bits
	typedef struct packed {
		logic         download;  // High for the whole transfer
		ioctl_index_t index;     // Stable while download is high
		ioctl_addr_t  addr;
		ioctl_data_t  dout;      // Low byte sits at the even address
		logic         wr;        // Single-cycle write strobe
	} ioctl_bus_t;

	// ======================================
	// Download kinds
	// ======================================

	// At most one flag is high at a time
	typedef struct packed {
		logic bios;  // Boot ROM image
		logic cart;  // Game pak image
		logic code;  // Cheat code list
	} dl_flags_t;

	// Index values with a fixed meaning
	localparam ioctl_index_t INDEX_BIOS = 8'd0;
	localparam ioctl_index_t INDEX_CODE = 8'd255;  // All ones

	// Every other index is a cartridge, bits 7:6 give its type

endpackage

`default_nettype wire

/* rom_writer.sv */
`timescale 1ns/1ps
`default_nettype none

module rom_writer import ioctl_pkg::*, gba_load_pkg::*; (
	input  wire             clk_sys,
	input  wire             reset,
	input  wire ioctl_bus_t host,
	input  wire             cart_active,
	input  wire             mem_ack,      // One pulse per request
	output rom_req_t        rom,
	output logic            ioctl_wait
);

	typedef enum logic {
		WAIT_IDLE,  // Host may write
		WAIT_BUSY   // Request out, memory not done yet
	} wait_state_t;

	wait_state_t state;
	logic        req_q;
	rom_addr_t   addr_q;
	ioctl_data_t data_q;
	logic        cart_wr;

	assign cart_wr    = cart_active & host.wr;
	assign ioctl_wait = (state == WAIT_BUSY);  // Back pressure to the host
	assign rom        = '{req: req_q, addr: addr_q, data: data_q};

	// Wait FSM
	always_ff @(posedge clk_sys) begin
		if (reset || !cart_active) begin
			state <= WAIT_IDLE;  // No wait outside a cartridge download
		end else begin
			if (cart_wr) state <= WAIT_BUSY;
			if (mem_ack) state <= WAIT_IDLE;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) req_q <= 1'b0;
		else req_q <= cart_wr;  // One request per host write
	end

	// Payload, halfword address shifted up to the ROM base
	always_ff @(posedge clk_sys) begin
		if (cart_wr) begin
			addr_q <= host.addr[26:1] + ROM_START[26:1];
			data_q <= host.dout;
		end
	end

endmodule

`default_nettype wire

/* src.f */
ioctl_pkg.sv
gba_load_pkg.sv
download_decoder.sv
cart_scanner.sv
cart_quirks.sv
bios_loader.sv
cheat_loader.sv
rom_writer.sv
gba_loader_top.sv
tb_gba_loader.sv

/* tb_gba_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_gba_loader import ioctl_pkg::*, gba_load_pkg::*;;

	logic        clk_sys = 1'b0;
	logic        reset;
	ioctl_bus_t  host;
	logic        homebrew_bios;
	logic        mem_ack;
	logic        ioctl_wait;
	rom_req_t    rom;
	logic        bios_wr;
	bios_addr_t  bios_addr;
	bios_word_t  bios_data;
	cheat_code_t cheat_code;
	logic        cheat_valid;
	logic        cheat_clear;
	logic        cart_loaded;
	cart_type_t  cart_type;
	logic        flash_1m;
	ioctl_addr_t last_addr;
	logic        sram_quirk;
	logic        remap_quirk;

	// Expected values, set by the stimulus on the falling edge
	int          value_errors = 0;
	int          timeout_errors = 0;
	logic [31:0] data_rng = 32'd16;  // Stimulus data
	logic [31:0] ack_rng  = 32'd16;  // Memory ack delays
	logic        in_cart;            // Host side view of a cartridge download
	int          mark;               // 1 ends the marker, 2 is the title check write
	ioctl_addr_t last_wr_addr;
	rom_addr_t   exp_rom_addr;
	ioctl_data_t exp_rom_data;
	bios_addr_t  exp_bios_addr;
	bios_word_t  exp_bios_data;
	cheat_code_t exp_code;
	logic        exp_sram;
	logic        exp_remap;
	int          cart_writes = 0;
	int          rom_reqs = 0;
	int          bios_pulses = 0;
	int          cheat_pulses = 0;
	int          ack_delay = 0;

	gba_loader_top gba_loader_top_i (.*);

	always #10 clk_sys = ~clk_sys;  // 20 ns period

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	task automatic report_value(input string name, input logic [127:0] exp,
		input logic [127:0] act);
		value_errors++;
		$display("ERROR %s: expected %h, actual %h", name, exp, act);
	endtask

	task automatic next_data(output ioctl_data_t d);
		data_rng = xorshift32(data_rng);
		d        = data_rng[15:0];
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clk_sys);
	endtask

	// ========================================
	// Memory responder and pulse counters
	// ========================================

	always @(negedge clk_sys) begin
		mem_ack = 1'b0;
		if (reset) begin
			ack_delay = 0;
		end else if (ack_delay != 0) begin
			ack_delay = ack_delay - 1;
			if (ack_delay == 0) mem_ack = 1'b1;  // One-cycle ack
		end else if (rom.req) begin
			ack_rng   = xorshift32(ack_rng);
			ack_delay = 1 + int'(ack_rng % 6);  // 1 to 6 cycles
		end
		if (!reset) begin
			rom_reqs     += int'(rom.req);
			bios_pulses  += int'(bios_wr);
			cheat_pulses += int'(cheat_valid);
		end
	end

	// ========================================
	// Checking assertions
	// ========================================

	bios_word_chk: assert property (@(posedge clk_sys) disable iff (reset)
		bios_wr |-> (bios_addr == exp_bios_addr && bios_data == exp_bios_data))
		else report_value("bios_word", {exp_bios_addr, exp_bios_data},
			$sampled({bios_addr, bios_data}));

	clear_chk: assert property (@(posedge clk_sys) disable iff (reset)
		($rose(host.download) && host.index == 8'd255) |=> cheat_clear)
		else report_value("cheat_clear", 1, 0);

	code_chk: assert property (@(posedge clk_sys) disable iff (reset)
		cheat_valid |-> (cheat_code == exp_code))
		else report_value("cheat_code", exp_code, $sampled(cheat_code));

	rom_req_chk: assert property (@(posedge clk_sys) disable iff (reset)
		rom.req |-> (rom.addr == exp_rom_addr && rom.data == exp_rom_data))
		else report_value("rom_req", {exp_rom_addr, exp_rom_data},
			$sampled({rom.addr, rom.data}));

	wait_rise_chk: assert property (@(posedge clk_sys) disable iff (reset)
		(host.wr && in_cart) |=> ioctl_wait)
		else report_value("wait_rise", 1, 0);

	wait_hold_chk: assert property (@(posedge clk_sys) disable iff (reset)
		(ioctl_wait && !mem_ack) |=> ioctl_wait)
		else report_value("wait_hold", 1, 0);

	wait_drop_chk: assert property (@(posedge clk_sys) disable iff (reset)
		mem_ack |=> !ioctl_wait)
		else report_value("wait_drop", 0, 1);

	flash_chk: assert property (@(posedge clk_sys) disable iff (reset)
		(host.wr && mark == 1) |=> flash_1m)
		else report_value("flash_1m", 1, 0);

	quirk_chk: assert property (@(posedge clk_sys) disable iff (reset)
		(host.wr && mark == 2) |=> (sram_quirk == exp_sram && remap_quirk == exp_remap))
		else report_value("quirks", {exp_sram, exp_remap},
			$sampled({sram_quirk, remap_quirk}));

	// ========================================
	// Host side tasks
	// ========================================

	// One halfword, then wait for the memory to release the host
	task automatic host_write(input ioctl_addr_t addr, input ioctl_data_t data, input int tag);
		int t;
		@(negedge clk_sys);
		host.addr    = addr;
		host.dout    = data;
		host.wr      = 1'b1;
		mark         = tag;
		last_wr_addr = addr;
		if (in_cart) begin
			cart_writes++;
			exp_rom_addr = rom_addr_t'((32'(addr) + 32'(ROM_START)) >> 1);  // Halfword address
			exp_rom_data = data;
		end
		@(negedge clk_sys);
		host.wr = 1'b0;
		mark    = 0;
		t       = 0;
		while (ioctl_wait && t < 50) begin
			@(negedge clk_sys);
			t++;
		end
		if (ioctl_wait) begin
			timeout_errors++;
			$display("Timeout: ioctl_wait stayed high after the write to %h", addr);
		end
	endtask

	// Bytes from the top of the vector down, starting at an even base
	task automatic write_bytes(input ioctl_addr_t base, input logic [95:0] bytes,
		input int count, input int last_tag);
		logic [7:0] lo;
		logic [7:0] hi;
		for (int k = 0; k < count; k += 2) begin
			lo = bytes[95 - 8 * k -: 8];  // Even address takes the low byte
			hi = bytes[87 - 8 * k -: 8];
			host_write(base + ioctl_addr_t'(k), {hi, lo}, (k + 2 >= count) ? last_tag : 0);
		end
	endtask

	task automatic bios_burst(input logic homebrew);
		ioctl_data_t lo;
		ioctl_data_t hi;
		int          n;
		@(negedge clk_sys);
		host.download = 1'b1;
		host.index    = INDEX_BIOS;
		homebrew_bios = homebrew;
		wait_cycles(3);
		n = bios_pulses;
		next_data(lo);
		next_data(hi);
		exp_bios_addr = bios_addr_t'(10 >> 2);  // Word 2
		exp_bios_data = {hi, lo};
		host_write(27'd8, lo, 0);
		host_write(27'd10, hi, 0);
		wait_cycles(3);
		assert (bios_pulses == n + (homebrew ? 0 : 1))
			else report_value("bios_pulses", n + (homebrew ? 0 : 1), bios_pulses);
		host.download = 1'b0;
		homebrew_bios = 1'b0;
		wait_cycles(3);
	endtask

	task automatic load_cheats(input int codes);
		ioctl_data_t d;
		int          n;
		@(negedge clk_sys);
		host.download = 1'b1;
		host.index    = INDEX_CODE;
		n             = cheat_pulses;
		wait_cycles(3);
		for (int c = 0; c < codes; c++) begin
			for (int h = 0; h < 8; h++) begin
				next_data(d);
				exp_code[96 - 32 * (h / 2) + 16 * (h % 2) +: 16] = d;  // Flags field on top
				host_write(ioctl_addr_t'(16 * c + 2 * h), d, 0);
			end
			wait_cycles(1);  // Valid pulse is seen before the next code starts
		end
		wait_cycles(2);
		assert (cheat_pulses == n + codes)
			else report_value("cheat_pulses", n + codes, cheat_pulses);
		host.download = 1'b0;
		wait_cycles(3);
	endtask

	task automatic load_cart(input ioctl_index_t index, input cart_title_t title,
		input logic sram, input logic remap, input logic with_flash);
		ioctl_data_t d;
		int          t;
		@(negedge clk_sys);
		host.download = 1'b1;
		host.index    = index;
		in_cart       = 1'b1;
		exp_sram      = sram;
		exp_remap     = remap;
		wait_cycles(3);
		t = 0;
		while (!cart_loaded && t < 20) begin
			@(negedge clk_sys);
			t++;
		end
		if (!cart_loaded) begin
			timeout_errors++;
			$display("Timeout: cart_loaded never rose for index %0d", index);
		end
		assert (cart_type == index[7:6]) else report_value("cart_type", index[7:6], cart_type);
		for (int i = 0; i < 4; i++) begin
			next_data(d);
			host_write(ioctl_addr_t'(2 * i), d, 0);  // Plain ROM data
		end
		write_bytes(HEADER_TITLE_BASE, title, 12, 0);
		next_data(d);
		host_write(27'd172, d, 2);  // Title complete
		if (with_flash)
			write_bytes(27'h200, {8'h00, "FLASH1M_V", 16'h0000}, 10, 1);  // Starts at odd 0x201
		wait_cycles(2);
		host.download = 1'b0;
		in_cart       = 1'b0;
		wait_cycles(4);  // Flag drop, end pulse, latch
		assert (last_addr == last_wr_addr)
			else report_value("last_addr", last_wr_addr, last_addr);
		assert (flash_1m == with_flash) else report_value("flash_end", with_flash, flash_1m);
	endtask

	// ========================================
	// Test sequence
	// ========================================

	initial begin
		host          = '0;
		homebrew_bios = 1'b0;
		mem_ack       = 1'b0;
		reset         = 1'b1;
		in_cart       = 1'b0;
		mark          = 0;
		exp_rom_addr  = '0;
		exp_rom_data  = '0;
		exp_bios_addr = '0;
		exp_bios_data = '0;
		exp_code      = '0;
		exp_sram      = 1'b0;
		exp_remap     = 1'b0;
		last_wr_addr  = '0;
		repeat (10) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
		assert ({ioctl_wait, rom.req, bios_wr, cheat_valid, cheat_clear, cart_loaded,
			flash_1m, sram_quirk, remap_quirk} == '0)
			else report_value("reset_state", 0, {ioctl_wait, rom.req, bios_wr, cheat_valid,
				cheat_clear, cart_loaded, flash_1m, sram_quirk, remap_quirk});

		bios_burst(1'b0);
		bios_burst(1'b1);  // Homebrew BIOS keeps the built-in image
		load_cheats(2);
		load_cart(8'd64, {"SUPER MARIO", 8'h00}, 1'b1, 1'b1, 1'b1);
		load_cart(8'd128, "DBZ TAIKETSU", 1'b1, 1'b0, 1'b0);
		load_cart(8'd192, "NOT IN TABLE", 1'b0, 1'b0, 1'b0);
		wait_cycles(2);
		assert (rom_reqs == cart_writes) else report_value("rom_reqs", cart_writes, rom_reqs);

		$display("Value errors: %0d, timeout errors: %0d", value_errors, timeout_errors);
		if (value_errors == 0 && timeout_errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire
